// File: Bender.yml
package:
  name: uart_periph

sources:
  # rtl, package first
  - files:
      - rtl/uartPkg.sv
      - rtl/baudTickGen.sv
      - rtl/uartRec.sv
      - rtl/uartTrans.sv
      - rtl/uartFifo.sv
      - rtl/uartPeriph.sv

  # testbench
  - target: test
    files:
      - tests/uartPeriphTb.sv

// File: rtl/baudTickGen.sv
// baud tick generator: free running divider giving one oversampling tick per baudDivisor clocks
`timescale 1ns/10ps

module baudTickGen (
	input  logic clk,
	input  logic reset,
	output logic sTick		// one clock wide
);

	uartPkg::baudCnt divCnt;	// counts 0..baudDivisor-1

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
			sTick <= 1'b0;
		end
		else if (divCnt == uartPkg::baudCnt'(uartPkg::baudDivisor - 1))
		begin
			divCnt <= '0;		// wrap
			sTick <= 1'b1;		// tick on wrap
		end
		else
		begin
			divCnt <= divCnt + 1'b1;
			sTick <= 1'b0;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// ticks come exactly baudDivisor clocks apart
	tickPeriod: assert property (@(posedge clk) disable iff (reset)
		sTick |=> (!sTick [*uartPkg::baudDivisor-1]) ##1 sTick);

endmodule

// File: rtl/uartFifo.sv
// byte fifo: first word fall through, 16 entries, occupancy counter with empty and full flags
`timescale 1ns/10ps

module uartFifo (
	input  logic clk,
	input  logic reset,
	input  logic push,			// write strobe
	input  logic pop,			// read strobe
	input  uartPkg::uartByte din,
	output uartPkg::uartByte dout,		// head of queue
	output logic empty,
	output logic full
);

	uartPkg::uartByte mem [uartPkg::fifoDepth];	// storage, no reset
	uartPkg::fifoPtr wrPtr, rdPtr;
	uartPkg::fifoCnt count;			// entries held
	logic doPush, doPop;

	// strobes on a full / empty queue are dropped here
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	//////////////////////////////
	// pointers and count
	//////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;		// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	//////////////////////////////
	// storage
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= din;
	end

	assign dout = mem[rdPtr];		// head visible without a pop
	assign empty = (count == '0);
	assign full = (count == uartPkg::fifoCnt'(uartPkg::fifoDepth));

	//////////////////////////////
	// checks
	//////////////////////////////
	countBound: assert property (@(posedge clk) disable iff (reset)
		count <= uartPkg::fifoCnt'(uartPkg::fifoDepth));

	notEmptyAndFull: assert property (@(posedge clk) disable iff (reset)
		!(empty && full));

endmodule

// File: rtl/uartPeriph.sv
// uart peripheral top: tick generator, receiver, transmitter, rx and tx fifos, overrun, status
`timescale 1ns/10ps

module uartPeriph (
	input  logic clk,
	input  logic reset,
	input  logic rx,			// serial in
	output logic tx,			// serial out
	input  logic wrStrobe,			// processor write, pushes tx fifo
	input  uartPkg::uartByte wrData,
	input  logic rdStrobe,			// processor read, pops rx fifo
	output uartPkg::uartByte rdData,	// rx fifo head
	output uartPkg::uartByte status
);

	logic sTick;
	logic rxDoneTick, rxPush;
	uartPkg::uartByte rxByte;
	logic rxEmpty, rxFull;
	logic txEmpty, txFull;
	logic txStart, txDoneTick;
	uartPkg::uartByte txHead;
	logic overrun;				// sticky until reset
	logic txBusy;				// frame in flight

	//////////////////////////////
	// serial side
	//////////////////////////////
	baudTickGen u_tickGen (.clk(clk), .reset(reset), .sTick(sTick));

	uartRec u_rec (
		.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.rxDoneTick(rxDoneTick), .dOut(rxByte)
	);

	uartTrans u_trans (
		.clk(clk), .reset(reset), .sTick(sTick),
		.txReady(!txEmpty), .din(txHead),
		.txStart(txStart), .txDoneTick(txDoneTick), .tx(tx)
	);

	//////////////////////////////
	// queues
	//////////////////////////////
	assign rxPush = rxDoneTick && !rxFull;	// full queue drops the frame

	uartFifo rxFifo (
		.clk(clk), .reset(reset), .push(rxPush), .pop(rdStrobe),
		.din(rxByte), .dout(rdData), .empty(rxEmpty), .full(rxFull)
	);

	uartFifo txFifo (
		.clk(clk), .reset(reset), .push(wrStrobe), .pop(txStart),
		.din(wrData), .dout(txHead), .empty(txEmpty), .full(txFull)
	);

	// overrun flag and transmit activity
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overrun <= 1'b0;
			txBusy <= 1'b0;
		end
		else
		begin
			if (rxDoneTick && rxFull)
				overrun <= 1'b1;	// byte lost
			if (txStart)
				txBusy <= 1'b1;
			else if (txDoneTick)
				txBusy <= 1'b0;		// stop bit finished
		end
	end

	// status byte, upper bits zero
	always_comb
	begin
		status = '0;
		status[uartPkg::statRxNotEmpty] = !rxEmpty;
		status[uartPkg::statRxFull] = rxFull;
		status[uartPkg::statTxEmpty] = txEmpty;
		status[uartPkg::statTxFull] = txFull;
		status[uartPkg::statRxOverrun] = overrun;
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	// the line idles high between frames
	lineIdle: assert property (@(posedge clk) disable iff (reset)
		!txBusy |-> tx);

endmodule

// File: rtl/uartPkg.sv
// uart package: frame, baud and fifo constants, vector types, serial fsm states
package uartPkg;

	//////////////////////////////
	// frame format
	//////////////////////////////
	localparam int dataBits = 8;			// data bits per frame
	localparam int sbTick = 16;			// stop ticks, 16 = one stop bit
	localparam int overSample = 16;		// ticks per bit

	//////////////////////////////
	// baud rate
	//////////////////////////////
	localparam int baudDivisor = 4;		// clocks per tick, small for short sims
	localparam int baudCntWidth = 2;		// divider counter width

	//////////////////////////////
	// fifo geometry
	//////////////////////////////
	localparam int fifoDepth = 16;
	localparam int fifoAddrWidth = 4;		// log2 of depth
	localparam int fifoCntWidth = 5;		// one extra bit so full is countable

	// status byte bit positions, bits 7..5 read zero
	localparam int statRxNotEmpty = 0;
	localparam int statRxFull = 1;
	localparam int statTxEmpty = 2;
	localparam int statTxFull = 3;
	localparam int statRxOverrun = 4;

	//////////////////////////////
	// types
	//////////////////////////////
	typedef logic [dataBits-1:0] uartByte;		// one data byte
	typedef logic [fifoAddrWidth-1:0] fifoPtr;	// read / write pointer
	typedef logic [fifoCntWidth-1:0] fifoCnt;	// occupancy 0..fifoDepth
	typedef logic [3:0] tickCnt;			// oversampling tick counter
	typedef logic [2:0] bitCnt;			// data bit index
	typedef logic [baudCntWidth-1:0] baudCnt;	// baud divider count

	// shared by receiver and transmitter
	typedef enum logic [1:0] {
		idle,		// line high, waiting
		start,		// start bit
		data,		// data bits
		stop		// stop bit
	} uartState;

endpackage

// File: rtl/uartRec.sv
// uart receiver: 16x oversampled serial input, start bit centering, lsb first shift in
`timescale 1ns/10ps

module uartRec (
	input  logic clk,
	input  logic reset,
	input  logic sTick,			// oversampling tick
	input  logic rx,			// serial line, idle high
	output logic rxDoneTick,		// one cycle, byte ready
	output uartPkg::uartByte dOut		// last received byte
);

	uartPkg::uartState stateReg, stateNext;
	uartPkg::tickCnt sReg, sNext;		// tick counter within a bit
	uartPkg::bitCnt nReg, nNext;		// data bit counter
	uartPkg::uartByte bReg, bNext;		// shift register

	//////////////////////////////
	// state registers
	//////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	// data shifter, payload only
	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	//////////////////////////////
	// next state logic
	//////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			uartPkg::idle:
				if (!rx)				// falling edge, frame begins
				begin
					stateNext = uartPkg::start;
					sNext = '0;
				end
			uartPkg::start:
				if (sTick)
				begin
					// middle of start bit
					if (sReg == uartPkg::tickCnt'(uartPkg::overSample/2 - 1))
					begin
						stateNext = uartPkg::data;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::data:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::overSample - 1))	// mid bit
					begin
						sNext = '0;
						bNext = {rx, bReg[uartPkg::dataBits-1:1]};	// lsb first
						if (nReg == uartPkg::bitCnt'(uartPkg::dataBits - 1))
							stateNext = uartPkg::stop;	// all bits in
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::stop:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::sbTick - 1))
					begin
						stateNext = uartPkg::idle;
						rxDoneTick = 1'b1;		// stop bit not checked
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = uartPkg::idle;
		endcase
	end

	assign dOut = bReg;

	//////////////////////////////
	// checks
	//////////////////////////////

	// done only on a stop tick, and the fsm is back in idle afterwards
	doneInStop: assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> (sTick && stateReg == uartPkg::stop) ##1 (stateReg == uartPkg::idle));

	// start counts to half a bit, data to a full bit
	tickBound: assert property (@(posedge clk) disable iff (reset)
		(stateReg != uartPkg::stop) |->
		(sReg <= ((stateReg == uartPkg::start) ? 4'd7 : 4'd15)));

endmodule

// File: rtl/uartTrans.sv
// uart transmitter: start bit, lsb first data bits and stop bit at 16 ticks per bit
`timescale 1ns/10ps

module uartTrans (
	input  logic clk,
	input  logic reset,
	input  logic sTick,			// oversampling tick
	input  logic txReady,			// tx fifo not empty
	input  uartPkg::uartByte din,		// fifo head byte
	output logic txStart,			// one cycle, pops the fifo
	output logic txDoneTick,		// end of stop bit
	output logic tx				// serial line, registered
);

	uartPkg::uartState stateReg, stateNext;
	uartPkg::tickCnt sReg, sNext;
	uartPkg::bitCnt nReg, nNext;
	uartPkg::uartByte bReg, bNext;		// outgoing shift register
	logic txReg, txNext;

	//////////////////////////////
	// state registers
	//////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;			// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	//////////////////////////////
	// next state logic
	//////////////////////////////
	// line level changes together with the state, so every bit is one full bit time
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txStart = 1'b0;
		txDoneTick = 1'b0;
		case (stateReg)
			uartPkg::idle:
			begin
				txNext = 1'b1;
				if (txReady && sTick)		// start on a tick boundary
				begin
					stateNext = uartPkg::start;
					sNext = '0;
					bNext = din;		// grab head byte
					txNext = 1'b0;		// start bit
					txStart = 1'b1;
				end
			end
			uartPkg::start:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::overSample - 1))
					begin
						stateNext = uartPkg::data;
						sNext = '0;
						nNext = '0;
						txNext = bReg[0];	// first data bit
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::data:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::overSample - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == uartPkg::bitCnt'(uartPkg::dataBits - 1))
						begin
							stateNext = uartPkg::stop;
							txNext = 1'b1;	// stop level
						end
						else
						begin
							nNext = nReg + 1'b1;
							txNext = bReg[1];	// next bit up
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::stop:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::sbTick - 1))
					begin
						stateNext = uartPkg::idle;
						txDoneTick = 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = uartPkg::idle;
		endcase
	end

	assign tx = txReg;

	//////////////////////////////
	// checks
	//////////////////////////////
	idleHigh: assert property (@(posedge clk) disable iff (reset)
		(stateReg == uartPkg::idle) |-> tx);

	// a pop happens only from idle and the start bit follows at once
	startFromIdle: assert property (@(posedge clk) disable iff (reset)
		txStart |-> (stateReg == uartPkg::idle) ##1 (stateReg == uartPkg::start && !tx));

endmodule

// File: tb.f
rtl/uartPkg.sv
rtl/baudTickGen.sv
rtl/uartRec.sv
rtl/uartTrans.sv
rtl/uartFifo.sv
rtl/uartPeriph.sv
tests/uartPeriphTb.sv

// File: tests/uartPeriphTb.sv
// testbench for the uart peripheral: clock, reset, xorshift stimulus, line models, reference queues, checks, timeout
`timescale 1ns/10ps

module uartPeriphTb;

	localparam int bitCycles = uartPkg::overSample * uartPkg::baudDivisor;	// 64 clocks per bit
	localparam int frameCycles = (uartPkg::dataBits + 2) * bitCycles;	// start + data + stop
	localparam int gapMax = 32;			// idle clocks after an rx frame
	localparam int rxFrames = 20;
	localparam int overflowFrames = uartPkg::fifoDepth + 1;	// one more than fits
	localparam int burstFrames = uartPkg::fifoDepth;
	localparam int duplexFrames = 16;
	localparam int totalFrames = rxFrames + overflowFrames + burstFrames + 2 * duplexFrames;
	localparam int timeoutCycles = totalFrames * (frameCycles + gapMax) + 8000;

	logic clk, reset;
	logic rx, tx;
	logic wrStrobe, rdStrobe;
	uartPkg::uartByte wrData, rdData, status;

	logic [31:0] rngState;			// xorshift state
	int cycleCount;
	uartPkg::uartByte rxModel[$];		// bytes due on rdData, oldest first
	uartPkg::uartByte txModel[$];		// mirrors txFifo contents
	logic expOverrun;			// predicted sticky flag

	// duplex stimulus, drawn up front so the order of processes does not matter
	uartPkg::uartByte duplexRx[duplexFrames], duplexTx[duplexFrames];
	int duplexRxGap[duplexFrames], duplexTxGap[duplexFrames];

	uartPeriph u_dut (
		.clk(clk), .reset(reset), .rx(rx), .tx(tx),
		.wrStrobe(wrStrobe), .wrData(wrData),
		.rdStrobe(rdStrobe), .rdData(rdData), .status(status)
	);

	//////////////////////////////
	// clock and timeout
	//////////////////////////////
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;		// 4 ns period
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d clock cycles", timeoutCycles);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped by the cycle limit");
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic uartPkg::uartByte randByte();
		logic [31:0] r;
		r = nextRand();
		return r[7:0];		// low byte only
	endfunction

	// status from queue occupancy and the overrun flag
	function automatic uartPkg::uartByte predictStatus(int rxCount, int txCount);
		uartPkg::uartByte s;
		s = '0;
		s[uartPkg::statRxNotEmpty] = (rxCount != 0);
		s[uartPkg::statRxFull] = (rxCount == uartPkg::fifoDepth);
		s[uartPkg::statTxEmpty] = (txCount == 0);
		s[uartPkg::statTxFull] = (txCount == uartPkg::fifoDepth);
		s[uartPkg::statRxOverrun] = expOverrun;
		return s;
	endfunction

	task automatic checkValue(string name, uartPkg::uartByte expected, uartPkg::uartByte actual);
		assert (actual === expected)
		else
		begin
			$display("** Error [%s] expected 0x%02h, actual 0x%02h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic waitCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic driveBit(logic level);
		rx = level;
		repeat (bitCycles) waitCycle();
	endtask

	// start bit, data lsb first, stop bit, then idle
	task automatic sendFrame(uartPkg::uartByte b, int gap);
		driveBit(1'b0);
		for (int i = 0; i < uartPkg::dataBits; i++)
			driveBit(b[i]);
		driveBit(1'b1);
		repeat (gap) waitCycle();
	endtask

	task automatic writeByte(uartPkg::uartByte b);
		logic accepted;
		accepted = (txModel.size() < uartPkg::fifoDepth);	// full queue ignores the write
		wrData = b;
		wrStrobe = 1'b1;
		waitCycle();
		wrStrobe = 1'b0;
		if (accepted)
			txModel.push_back(b);		// in the fifo from this edge on
	endtask

	task automatic waitRxData();
		while (!status[uartPkg::statRxNotEmpty])
			waitCycle();
	endtask

	// compares head and status, then pops with a one cycle strobe
	task automatic readAndCheck(string name, int rxCount);
		uartPkg::uartByte expected;
		#1;				// mid cycle, model updates done
		assert (rxModel.size() != 0)
		else
		begin
			$display("%s: the receive queue holds a byte that was never sent", name);
			$display("TESTBENCH FAILED");
			$fatal(1, "unexpected receive data");
		end
		expected = rxModel.pop_front();
		checkValue({name, " status"}, predictStatus(rxCount, txModel.size()), status);
		checkValue({name, " data"}, expected, rdData);
		waitCycle();
		rdStrobe = 1'b1;
		waitCycle();
		rdStrobe = 1'b0;
	endtask

	// line monitor: finds the start edge, samples mid bit
	task automatic receiveTxFrame(string name);
		uartPkg::uartByte expected, got;
		while (tx !== 1'b0)
			waitCycle();
		assert (txModel.size() != 0)
		else
		begin
			$display("%s: a frame started on tx although nothing was written", name);
			$display("TESTBENCH FAILED");
			$fatal(1, "unexpected transmit frame");
		end
		expected = txModel.pop_front();	// popped from txFifo at this edge
		repeat (bitCycles / 2) waitCycle();
		checkValue({name, " start bit"}, 8'h00, {7'b0, tx});
		for (int i = 0; i < uartPkg::dataBits; i++)
		begin
			repeat (bitCycles) waitCycle();
			got[i] = tx;
		end
		repeat (bitCycles) waitCycle();
		checkValue({name, " stop bit"}, 8'h01, {7'b0, tx});
		checkValue({name, " data"}, expected, got);
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial
	begin
		uartPkg::uartByte b;
		rngState = 32'hca7f;
		expOverrun = 1'b0;
		reset = 1'b1;
		rx = 1'b1;			// line idles high
		wrStrobe = 1'b0;
		wrData = '0;
		rdStrobe = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		// state after reset
		checkValue("reset status", 8'h04, status);
		checkValue("reset tx", 8'h01, {7'b0, tx});

		// single frames, each read back at once
		for (int i = 0; i < rxFrames; i++)
		begin
			b = randByte();
			sendFrame(b, nextRand() % gapMax);
			rxModel.push_back(b);
			waitRxData();
			readAndCheck("rx single", rxModel.size());
			checkValue("rx status after read", predictStatus(rxModel.size(), txModel.size()),
				status);
		end

		// 17 frames unread, the last one is lost
		for (int i = 0; i < overflowFrames; i++)
		begin
			b = randByte();
			sendFrame(b, nextRand() % gapMax);
			if (rxModel.size() < uartPkg::fifoDepth)
				rxModel.push_back(b);
			else
				expOverrun = 1'b1;
		end
		checkValue("rx overflow status", predictStatus(rxModel.size(), txModel.size()), status);
		while (rxModel.size() != 0)
			readAndCheck("rx overflow read", rxModel.size());
		checkValue("overrun after drain", predictStatus(0, txModel.size()), status);

		// back to back writes against the line monitor
		fork
			begin
				for (int i = 0; i < burstFrames; i++)
					writeByte(randByte());
			end
			begin
				for (int i = 0; i < burstFrames; i++)
					receiveTxFrame("tx burst");
			end
		join
		checkValue("tx burst status", predictStatus(0, txModel.size()), status);

		// full duplex
		for (int i = 0; i < duplexFrames; i++)
		begin
			duplexRx[i] = randByte();
			duplexRxGap[i] = nextRand() % gapMax;
			duplexTx[i] = randByte();
			duplexTxGap[i] = 64 + nextRand() % 768;	// roughly keeps pace with the line
		end
		fork
			begin
				for (int i = 0; i < duplexFrames; i++)
				begin
					rxModel.push_back(duplexRx[i]);
					sendFrame(duplexRx[i], duplexRxGap[i]);
				end
			end
			begin
				// one frame at a time, so never more than one byte waiting
				for (int i = 0; i < duplexFrames; i++)
				begin
					waitRxData();
					readAndCheck("duplex rx", 1);
				end
			end
			begin
				for (int i = 0; i < duplexFrames; i++)
				begin
					repeat (duplexTxGap[i]) waitCycle();
					while (txModel.size() >= uartPkg::fifoDepth)
						waitCycle();
					writeByte(duplexTx[i]);
				end
			end
			begin
				for (int i = 0; i < duplexFrames; i++)
					receiveTxFrame("duplex tx");
			end
		join
		checkValue("final status", predictStatus(rxModel.size(), txModel.size()), status);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
